//--- rtl/tmu_span_pkg.sv
////////////////////
// Shared widths and types for the texture span unit
// Frame-buffer word addresses, fixed-point texture coordinates,
// pixel counts, RGB565 colour, brightness and controller states
////////////////////

package tmu_span_pkg;

	// Word address into either frame buffer (16-bit words)
	localparam int ADR_W = 25;

	// Fraction bits of a texture coordinate
	localparam int FRAC_W = 6;

	typedef logic [ADR_W-1:0] adr_t;

	// Sign bit, 11 integer bits and FRAC_W fraction bits
	typedef logic signed [17:0] coord_t;

	// Resolutions, rectangle sizes and pixel positions
	typedef logic [10:0] res_t;

	// RGB565 with red in the top five bits
	typedef logic [15:0] color_t;

	// Brightness 0..63, where 63 leaves the colour unchanged
	typedef logic [5:0] level_t;

	typedef enum logic [1:0] {
		IDLE,
		WALK,
		DRAIN
	} ctrl_state_t;

endpackage

//--- rtl/tmu_span_if.sv
////////////////////
// Stream interfaces between the span stages
// coord_if, fetch_if and texel_if, each with source and sink modports
////////////////////

`timescale 1ns/1ps

// Destination position and texture coordinate of one pixel
interface coord_if
	import tmu_span_pkg::*;
();
	logic valid;
	logic ready;
	res_t dst_x;
	res_t dst_y;
	coord_t tex_x;
	coord_t tex_y;

	modport source (output valid, output dst_x, output dst_y, output tex_x, output tex_y,
		input ready);
	modport sink (input valid, input dst_x, input dst_y, input tex_x, input tex_y,
		output ready);
endinterface

// Destination and texel word addresses of one pixel
interface fetch_if
	import tmu_span_pkg::*;
();
	logic valid;
	logic ready;
	adr_t dadr;
	adr_t tadr;

	modport source (output valid, output dadr, output tadr, input ready);
	modport sink (input valid, input dadr, input tadr, output ready);
endinterface

// Fetched texel paired with the address it will be written to
interface texel_if
	import tmu_span_pkg::*;
();
	logic valid;
	logic ready;
	adr_t dadr;
	color_t color;

	modport source (output valid, output dadr, output color, input ready);
	modport sink (input valid, input dadr, input color, output ready);
endinterface

//--- rtl/span_ctrl_fsm.sv
////////////////////
// Run controller
// Starts the rectangle walk, waits for the stages to drain
// and pulses done as busy falls
////////////////////

`timescale 1ns/1ps

module span_ctrl_fsm import tmu_span_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic start_i,
	input logic walk_last_i,
	input logic walker_idle_i,
	input logic addr_idle_i,
	input logic fetch_idle_i,
	input logic decay_idle_i,
	output logic walk_en_o,
	output logic busy_o,
	output logic done_o
);
	ctrl_state_t state_q;
	ctrl_state_t state_d;
	logic all_idle;

	// Every stage holds its pixel in a register, so nothing hides between them
	assign all_idle = walker_idle_i & addr_idle_i & fetch_idle_i & decay_idle_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start_i) begin
					state_d = WALK;
				end
			end
			WALK: begin
				if (walk_last_i) begin
					state_d = DRAIN;
				end
			end
			DRAIN: begin
				if (all_idle) begin
					state_d = IDLE;
				end
			end
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= IDLE;
			done_o <= 1'b0;
		end else begin
			state_q <= state_d;
			// Registered so that it lines up with the return to IDLE
			done_o <= (state_q == DRAIN) && all_idle;
		end
	end

	assign walk_en_o = (state_q == WALK);
	assign busy_o = (state_q != IDLE);

endmodule

//--- rtl/pixel_walker.sv
////////////////////
// Raster walk over the destination rectangle
// Steps the texture coordinate per pixel and per row
////////////////////

`timescale 1ns/1ps

module pixel_walker import tmu_span_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic walk_en_i,
	input res_t dst_w_i,
	input res_t dst_h_i,
	input coord_t tex_x0_i,
	input coord_t tex_y0_i,
	input coord_t tex_dx_i,
	input coord_t tex_dy_i,
	output logic walk_last_o,
	output logic idle_o,
	coord_if.source coord_o
);
	logic valid_q;
	res_t x_q;
	res_t y_q;
	coord_t tx_q;
	coord_t ty_q;
	logic load;
	logic step;
	logic last_col;
	logic last_row;

	// Valid stays high for the whole walk, so a low valid inside WALK means not yet started
	assign load = walk_en_i && !valid_q;
	assign step = valid_q && coord_o.ready;
	assign last_col = (x_q == dst_w_i - res_t'(1));
	assign last_row = (y_q == dst_h_i - res_t'(1));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (step && last_col && last_row) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			x_q <= '0;
			y_q <= '0;
			tx_q <= tex_x0_i;
			ty_q <= tex_y0_i;
		end else if (step) begin
			if (last_col) begin
				// New row restarts u at the origin and moves v by one row step
				x_q <= '0;
				y_q <= y_q + res_t'(1);
				tx_q <= tex_x0_i;
				ty_q <= ty_q + tex_dy_i;
			end else begin
				x_q <= x_q + res_t'(1);
				tx_q <= tx_q + tex_dx_i;
			end
		end
	end

	assign coord_o.valid = valid_q;
	assign coord_o.dst_x = x_q;
	assign coord_o.dst_y = y_q;
	assign coord_o.tex_x = tx_q;
	assign coord_o.tex_y = ty_q;

	assign walk_last_o = step && last_col && last_row;
	assign idle_o = !valid_q;

endmodule

//--- rtl/tex_addr_gen.sv
////////////////////
// Texture coordinate mask and clamp
// Texel and destination word address generation
////////////////////

`timescale 1ns/1ps

module tex_addr_gen import tmu_span_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input adr_t tex_fbuf_i,
	input adr_t dst_fbuf_i,
	input res_t tex_hres_i,
	input res_t tex_vres_i,
	input res_t dst_hres_i,
	input coord_t tex_hmask_i,
	input coord_t tex_vmask_i,
	coord_if.sink coord_i,
	fetch_if.source fetch_o,
	output logic idle_o
);
	logic valid_q;
	adr_t tadr_q;
	adr_t dadr_q;
	res_t tx_c;
	res_t ty_c;
	logic take;

	// Nearest sampling: mask, drop the fraction, then clamp into the texture
	function automatic res_t clamp_coord(coord_t c, coord_t mask, res_t res);
		coord_t masked;
		logic signed [17-FRAC_W:0] ipart;
		masked = c & mask;
		ipart = masked[17:FRAC_W];
		if (ipart[17-FRAC_W]) begin
			return '0;
		end else if (res_t'(ipart) >= res) begin
			return res - res_t'(1);
		end
		return res_t'(ipart);
	endfunction

	assign tx_c = clamp_coord(coord_i.tex_x, tex_hmask_i, tex_hres_i);
	assign ty_c = clamp_coord(coord_i.tex_y, tex_vmask_i, tex_vres_i);

	assign coord_i.ready = !valid_q || fetch_o.ready;
	assign take = coord_i.valid && coord_i.ready;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			valid_q <= 1'b0;
		end else if (coord_i.ready) begin
			valid_q <= coord_i.valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take) begin
			tadr_q <= tex_fbuf_i + adr_t'(ty_c) * adr_t'(tex_hres_i) + adr_t'(tx_c);
			dadr_q <= dst_fbuf_i + adr_t'(coord_i.dst_y) * adr_t'(dst_hres_i)
				+ adr_t'(coord_i.dst_x);
		end
	end

	assign fetch_o.valid = valid_q;
	assign fetch_o.tadr = tadr_q;
	assign fetch_o.dadr = dadr_q;
	assign idle_o = !valid_q;

endmodule

//--- rtl/texel_fetch.sv
////////////////////
// Texel read issue and response pairing
// One ring of FETCH_DEPTH slots serves both the reads in flight
// and the texels waiting for the next stage
////////////////////

`timescale 1ns/1ps

module texel_fetch import tmu_span_pkg::*; #(
	parameter int FETCH_DEPTH = 4
) (
	input logic sys_clk,
	input logic sys_rst,
	fetch_if.sink fetch_i,
	output logic tex_req_valid_o,
	input logic tex_req_ready_i,
	output adr_t tex_req_adr_o,
	input logic tex_resp_valid_i,
	input color_t tex_resp_dat_i,
	texel_if.source texel_o,
	output logic idle_o
);
	localparam int IDX_W = $clog2(FETCH_DEPTH);

	adr_t dadr_mem [FETCH_DEPTH];
	color_t color_mem [FETCH_DEPTH];

	// Slots run issue_ptr ahead of resp_ptr ahead of out_ptr, all in request order
	logic [IDX_W:0] issue_ptr;
	logic [IDX_W:0] resp_ptr;
	logic [IDX_W:0] out_ptr;
	logic [IDX_W:0] used;
	logic has_room;
	logic issue;
	logic out_take;

	// Slots stay taken until their texel is passed on, so a response always has a home
	assign used = issue_ptr - out_ptr;
	assign has_room = !used[IDX_W];

	// has_room can only turn true while a request waits, so valid never drops early
	assign tex_req_valid_o = fetch_i.valid && has_room;
	assign tex_req_adr_o = fetch_i.tadr;
	assign fetch_i.ready = tex_req_ready_i && has_room;
	assign issue = fetch_i.valid && fetch_i.ready;

	assign texel_o.valid = (resp_ptr != out_ptr);
	assign texel_o.dadr = dadr_mem[out_ptr[IDX_W-1:0]];
	assign texel_o.color = color_mem[out_ptr[IDX_W-1:0]];
	assign out_take = texel_o.valid && texel_o.ready;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			issue_ptr <= '0;
			resp_ptr <= '0;
			out_ptr <= '0;
		end else begin
			if (issue) begin
				issue_ptr <= issue_ptr + 1'b1;
			end
			if (tex_resp_valid_i) begin
				resp_ptr <= resp_ptr + 1'b1;
			end
			if (out_take) begin
				out_ptr <= out_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (issue) begin
			dadr_mem[issue_ptr[IDX_W-1:0]] <= fetch_i.dadr;
		end
		if (tex_resp_valid_i) begin
			color_mem[resp_ptr[IDX_W-1:0]] <= tex_resp_dat_i;
		end
	end

	assign idle_o = (issue_ptr == out_ptr);

endmodule

//--- rtl/color_decay.sv
////////////////////
// Brightness scaling and chroma-key drop on RGB565 texels
// Drives the pixel write port from its output register
////////////////////

`timescale 1ns/1ps

module color_decay import tmu_span_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input level_t brightness_i,
	input logic chroma_key_en_i,
	input color_t chroma_key_i,
	texel_if.sink texel_i,
	output logic pix_valid_o,
	output adr_t pix_adr_o,
	output color_t pix_dat_o,
	input logic pix_ready_i,
	output logic idle_o
);
	logic take;
	logic keyed;
	color_t scaled;

	// Channel times (brightness + 1), divided by 64
	function automatic logic [5:0] scale(logic [5:0] c, level_t b);
		logic [12:0] prod;
		prod = c * ({1'b0, b} + 7'd1);
		return prod[11:6];
	endfunction

	assign keyed = chroma_key_en_i && (texel_i.color == chroma_key_i);
	assign texel_i.ready = !pix_valid_o || pix_ready_i;
	assign take = texel_i.valid && texel_i.ready;

	// Red and blue are five bits wide and come back below 32
	assign scaled[15:11] = 5'(scale({1'b0, texel_i.color[15:11]}, brightness_i));
	assign scaled[10:5] = scale(texel_i.color[10:5], brightness_i);
	assign scaled[4:0] = 5'(scale({1'b0, texel_i.color[4:0]}, brightness_i));

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pix_valid_o <= 1'b0;
		end else if (take && !keyed) begin
			pix_valid_o <= 1'b1;
		end else if (pix_ready_i) begin
			pix_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (take && !keyed) begin
			pix_adr_o <= texel_i.dadr;
			pix_dat_o <= scaled;
		end
	end

	assign idle_o = !pix_valid_o;

endmodule

//--- rtl/tmu_span_top.sv
////////////////////
// Texture span unit top level
// Controller, walker, address stage, texel fetch and colour stage
////////////////////

`timescale 1ns/1ps

module tmu_span_top import tmu_span_pkg::*; #(
	parameter int FETCH_DEPTH = 4
) (
	input logic sys_clk,
	input logic sys_rst,
	input adr_t tex_fbuf_i,
	input res_t tex_hres_i,
	input res_t tex_vres_i,
	input coord_t tex_hmask_i,
	input coord_t tex_vmask_i,
	input coord_t tex_x0_i,
	input coord_t tex_y0_i,
	input coord_t tex_dx_i,
	input coord_t tex_dy_i,
	input adr_t dst_fbuf_i,
	input res_t dst_hres_i,
	input res_t dst_w_i,
	input res_t dst_h_i,
	input level_t brightness_i,
	input logic chroma_key_en_i,
	input color_t chroma_key_i,
	input logic start_i,
	output logic busy_o,
	output logic done_o,
	output logic tex_req_valid_o,
	input logic tex_req_ready_i,
	output adr_t tex_req_adr_o,
	input logic tex_resp_valid_i,
	input color_t tex_resp_dat_i,
	output logic pix_valid_o,
	input logic pix_ready_i,
	output adr_t pix_adr_o,
	output color_t pix_dat_o
);
	logic walk_en;
	logic walk_last;
	logic walker_idle;
	logic addr_idle;
	logic fetch_idle;
	logic decay_idle;

	coord_if coord_bus ();
	fetch_if fetch_bus ();
	texel_if texel_bus ();

	span_ctrl_fsm span_ctrl_fsm_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.start_i(start_i),
		.walk_last_i(walk_last),
		.walker_idle_i(walker_idle),
		.addr_idle_i(addr_idle),
		.fetch_idle_i(fetch_idle),
		.decay_idle_i(decay_idle),
		.walk_en_o(walk_en),
		.busy_o(busy_o),
		.done_o(done_o)
	);

	pixel_walker pixel_walker_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.walk_en_i(walk_en),
		.dst_w_i(dst_w_i),
		.dst_h_i(dst_h_i),
		.tex_x0_i(tex_x0_i),
		.tex_y0_i(tex_y0_i),
		.tex_dx_i(tex_dx_i),
		.tex_dy_i(tex_dy_i),
		.walk_last_o(walk_last),
		.idle_o(walker_idle),
		.coord_o(coord_bus.source)
	);

	tex_addr_gen tex_addr_gen_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tex_fbuf_i(tex_fbuf_i),
		.dst_fbuf_i(dst_fbuf_i),
		.tex_hres_i(tex_hres_i),
		.tex_vres_i(tex_vres_i),
		.dst_hres_i(dst_hres_i),
		.tex_hmask_i(tex_hmask_i),
		.tex_vmask_i(tex_vmask_i),
		.coord_i(coord_bus.sink),
		.fetch_o(fetch_bus.source),
		.idle_o(addr_idle)
	);

	texel_fetch #(
		.FETCH_DEPTH(FETCH_DEPTH)
	) texel_fetch_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.fetch_i(fetch_bus.sink),
		.tex_req_valid_o(tex_req_valid_o),
		.tex_req_ready_i(tex_req_ready_i),
		.tex_req_adr_o(tex_req_adr_o),
		.tex_resp_valid_i(tex_resp_valid_i),
		.tex_resp_dat_i(tex_resp_dat_i),
		.texel_o(texel_bus.source),
		.idle_o(fetch_idle)
	);

	color_decay color_decay_inst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.brightness_i(brightness_i),
		.chroma_key_en_i(chroma_key_en_i),
		.chroma_key_i(chroma_key_i),
		.texel_i(texel_bus.sink),
		.pix_valid_o(pix_valid_o),
		.pix_adr_o(pix_adr_o),
		.pix_dat_o(pix_dat_o),
		.pix_ready_i(pix_ready_i),
		.idle_o(decay_idle)
	);

endmodule

//--- verification/tmu_span_chk.sv
////////////////////
// Concurrent checks bound into the span unit top level
// Stalled streams hold their payload, done is one pulse as busy falls,
// start raises busy and nothing is offered while idle
////////////////////

`timescale 1ns/1ps

module tmu_span_chk import tmu_span_pkg::*; (
	input logic sys_clk,
	input logic sys_rst,
	input logic start_i,
	input logic busy_o,
	input logic done_o,
	input logic tex_req_valid_o,
	input logic tex_req_ready_i,
	input adr_t tex_req_adr_o,
	input logic pix_valid_o,
	input logic pix_ready_i,
	input adr_t pix_adr_o,
	input color_t pix_dat_o
);
	int unsigned fail_count;

	req_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		tex_req_valid_o && !tex_req_ready_i |=> tex_req_valid_o && $stable(tex_req_adr_o))
	else begin
		$error("Stalled texel request dropped valid or changed its address");
		fail_count++;
	end

	pix_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pix_valid_o && !pix_ready_i |=> pix_valid_o && $stable(pix_adr_o) && $stable(pix_dat_o))
	else begin
		$error("Stalled pixel dropped valid or changed its payload");
		fail_count++;
	end

	// Done lasts one cycle and comes as busy goes low
	done_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		done_o |-> !busy_o && $past(busy_o) ##1 !done_o)
	else begin
		$error("done_o was not a single pulse on the falling edge of busy_o");
		fail_count++;
	end

	busy_rise: assert property (@(posedge sys_clk) disable iff (sys_rst)
		start_i && !busy_o |=> busy_o)
	else begin
		$error("busy_o did not rise after start_i");
		fail_count++;
	end

	idle_quiet: assert property (@(posedge sys_clk) disable iff (sys_rst)
		!busy_o |-> !pix_valid_o && !tex_req_valid_o)
	else begin
		$error("Pixel or texel request offered while the unit was idle");
		fail_count++;
	end

endmodule

//--- verification/tmu_span_tb.sv
////////////////////
// Testbench for the texture span unit
// Clock and reset, in-order texel memory model with random stalls,
// raster-order pixel scoreboard, directed tests and the final report
////////////////////

`timescale 1ns/1ps

module tmu_span_tb import tmu_span_pkg::*; ();
	// Copy, mask, brightness, key, back-pressure and two control runs
	localparam int TOTAL_PIX = 12 + 30 + 12 + 10 + 12 + 24;
	localparam int CYCLE_LIMIT = 20 * TOTAL_PIX + 200;
	localparam int MAX_PIX = 256;
	localparam adr_t TEX_BASE = 25'h01_2340;
	localparam adr_t DST_BASE = 25'h10_0000;
	localparam res_t TEX_HRES = 11'd16;

	logic sys_clk;
	logic sys_rst;
	adr_t tex_fbuf_i, dst_fbuf_i;
	res_t tex_hres_i, tex_vres_i, dst_hres_i, dst_w_i, dst_h_i;
	coord_t tex_hmask_i, tex_vmask_i, tex_x0_i, tex_y0_i, tex_dx_i, tex_dy_i;
	level_t brightness_i;
	logic chroma_key_en_i;
	color_t chroma_key_i;
	logic start_i, busy_o, done_o;
	logic tex_req_valid_o, tex_req_ready_i, tex_resp_valid_i;
	adr_t tex_req_adr_o;
	color_t tex_resp_dat_i;
	logic pix_valid_o, pix_ready_i;
	adr_t pix_adr_o;
	color_t pix_dat_o;

	logic rand_mode;
	adr_t exp_adr [MAX_PIX];
	color_t exp_dat [MAX_PIX];
	int exp_n, rd_idx, sb_errors, chk_errors, done_count, cycles;
	int tests_run, tests_failed;

	tmu_span_top #(.FETCH_DEPTH(4)) tmu_span_top_inst (.*);

	bind tmu_span_top tmu_span_chk tmu_span_chk_inst (
		.sys_clk(sys_clk), .sys_rst(sys_rst), .start_i(start_i), .busy_o(busy_o),
		.done_o(done_o), .tex_req_valid_o(tex_req_valid_o), .tex_req_ready_i(tex_req_ready_i),
		.tex_req_adr_o(tex_req_adr_o), .pix_valid_o(pix_valid_o), .pix_ready_i(pix_ready_i),
		.pix_adr_o(pix_adr_o), .pix_dat_o(pix_dat_o)
	);

	always begin
		sys_clk = 1'b0;
		#4;
		sys_clk = 1'b1;
		#4;
	end

	always @(posedge sys_clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: %0d cycles passed before the tests finished", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	function automatic color_t texel_at(adr_t a);
		return a[15:0] ^ 16'hA5C3;
	endfunction

	// Integer part of the masked coordinate, forced into 0..res-1
	function automatic int clamp_tex(coord_t c, coord_t mask, res_t res);
		coord_t m;
		int ip;
		m = c & mask;
		ip = int'(m) >>> FRAC_W;
		if (ip < 0) begin
			return 0;
		end
		if (ip >= int'(res)) begin
			return int'(res) - 1;
		end
		return ip;
	endfunction

	function automatic color_t dim_color(color_t c, level_t lvl);
		int k, r, g, b;
		k = int'(lvl) + 1;
		r = (int'(c[15:11]) * k) / 64;
		g = (int'(c[10:5]) * k) / 64;
		b = (int'(c[4:0]) * k) / 64;
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	// Appends the pixels of one run in raster order, keyed texels left out
	task automatic predict_run(output int count);
		int x, y, tx, ty;
		coord_t u, v;
		adr_t tadr, dadr;
		color_t texel;
		count = 0;
		for (y = 0; y < int'(dst_h_i); y++) begin
			for (x = 0; x < int'(dst_w_i); x++) begin
				u = coord_t'(int'(tex_x0_i) + x * int'(tex_dx_i));
				v = coord_t'(int'(tex_y0_i) + y * int'(tex_dy_i));
				tx = clamp_tex(u, tex_hmask_i, tex_hres_i);
				ty = clamp_tex(v, tex_vmask_i, tex_vres_i);
				tadr = adr_t'(longint'(tex_fbuf_i) + longint'(ty) * longint'(tex_hres_i)
					+ longint'(tx));
				dadr = adr_t'(longint'(dst_fbuf_i) + longint'(y) * longint'(dst_hres_i)
					+ longint'(x));
				texel = texel_at(tadr);
				if (!(chroma_key_en_i && texel == chroma_key_i)) begin
					exp_adr[exp_n] = dadr;
					exp_dat[exp_n] = dim_color(texel, brightness_i);
					exp_n++;
					count++;
				end
			end
		end
	endtask

	task automatic load_copy_setup();
		tex_fbuf_i <= TEX_BASE;
		tex_hres_i <= TEX_HRES;
		tex_vres_i <= 11'd16;
		tex_hmask_i <= 18'h3FFFF;
		tex_vmask_i <= 18'h3FFFF;
		tex_x0_i <= 18'sd0;
		tex_y0_i <= 18'sd0;
		tex_dx_i <= 18'sd64;
		tex_dy_i <= 18'sd64;
		dst_fbuf_i <= DST_BASE;
		dst_hres_i <= 11'd640;
		dst_w_i <= 11'd4;
		dst_h_i <= 11'd3;
		brightness_i <= 6'd63;
		chroma_key_en_i <= 1'b0;
		chroma_key_i <= 16'h0000;
	endtask

	task automatic run_test(input string name, input logic extra_start);
		int base_done, base_err, base_pix, expect_cnt, got, fails;
		fails = 0;
		@(posedge sys_clk);
		base_done = done_count;
		base_err = sb_errors;
		base_pix = exp_n;
		predict_run(expect_cnt);
		start_i <= 1'b1;
		@(posedge sys_clk);
		start_i <= 1'b0;
		if (extra_start) begin
			repeat (3) @(posedge sys_clk);
			assert (busy_o) else begin
				$display("busy_o was low when the repeated start was given");
				fails++;
			end
			start_i <= 1'b1;
			@(posedge sys_clk);
			start_i <= 1'b0;
		end
		while (done_o !== 1'b1) begin
			@(posedge sys_clk);
		end
		repeat (4) @(posedge sys_clk);
		got = rd_idx - base_pix;
		assert (done_count - base_done == 1) else begin
			$display("done_o pulsed %0d times in one run", done_count - base_done);
			fails++;
		end
		assert (got == expect_cnt) else begin
			$display("%0d pixels were written where %0d were predicted", got, expect_cnt);
			fails++;
		end
		assert (!busy_o) else begin
			$display("busy_o went high again after the run ended");
			fails++;
		end
		chk_errors += fails;
		fails += sb_errors - base_err;
		tests_run++;
		if (fails == 0) begin
			$display("Test %s: ok, %0d pixels", name, got);
		end else begin
			tests_failed++;
			$display("Test %s: %0d problems, %0d of %0d pixels", name, fails, got, expect_cnt);
		end
	endtask

	// Texel memory answers in request order after a random wait
	initial begin : mem_model
		adr_t req_q [$];
		int unsigned resp_wait;
		void'($urandom(32'h9ae1));
		tex_req_ready_i = 1'b0;
		tex_resp_valid_i = 1'b0;
		tex_resp_dat_i = 16'h0000;
		pix_ready_i = 1'b0;
		resp_wait = 0;
		forever begin
			@(posedge sys_clk);
			tex_resp_valid_i <= 1'b0;
			if (sys_rst) begin
				req_q.delete();
				tex_req_ready_i <= 1'b0;
				pix_ready_i <= 1'b0;
			end else begin
				if (req_q.size() > 0) begin
					if (resp_wait == 0) begin
						tex_resp_valid_i <= 1'b1;
						tex_resp_dat_i <= texel_at(req_q.pop_front());
						resp_wait = rand_mode ? $urandom_range(3, 0) : 0;
					end else begin
						resp_wait--;
					end
				end
				if (tex_req_valid_o && tex_req_ready_i) begin
					req_q.push_back(tex_req_adr_o);
				end
				tex_req_ready_i <= !rand_mode || ($urandom_range(3, 0) != 0);
				pix_ready_i <= !rand_mode || ($urandom_range(1, 0) == 1);
			end
		end
	end

	initial begin : scoreboard
		forever begin
			@(posedge sys_clk);
			if (!sys_rst && done_o) begin
				done_count++;
			end
			if (!sys_rst && pix_valid_o && pix_ready_i) begin
				assert (rd_idx < exp_n) else begin
					$display("Pixel at %h was written with no pixel left to expect", pix_adr_o);
					sb_errors++;
				end
				if (rd_idx < exp_n) begin
					assert (pix_adr_o == exp_adr[rd_idx]) else begin
						$display("** Error at %0t: pix_adr_o = %h, expected %h",
							$time, pix_adr_o, exp_adr[rd_idx]);
						sb_errors++;
					end
					assert (pix_dat_o == exp_dat[rd_idx]) else begin
						$display("** Error at %0t: pix_dat_o = %h, expected %h",
							$time, pix_dat_o, exp_dat[rd_idx]);
						sb_errors++;
					end
				end
				rd_idx++;
			end
		end
	end

	initial begin
		int bound_fails;
		sys_rst = 1'b1;
		start_i = 1'b0;
		rand_mode = 1'b0;
		load_copy_setup();
		repeat (3) @(posedge sys_clk);
		sys_rst <= 1'b0;
		run_test("plain_copy", 1'b0);
		// Negative origins, fractional steps and coordinates past the resolution and the mask
		load_copy_setup();
		dst_w_i <= 11'd6;
		dst_h_i <= 11'd5;
		tex_hres_i <= 11'd6;
		tex_vres_i <= 11'd4;
		tex_x0_i <= -18'sd100;
		tex_y0_i <= -18'sd30;
		tex_dx_i <= 18'sd150;
		tex_dy_i <= 18'sd150;
		tex_hmask_i <= 18'h301FF;
		tex_vmask_i <= 18'h301FF;
		run_test("mask_and_clamp", 1'b0);
		load_copy_setup();
		brightness_i <= 6'd31;
		run_test("brightness_31", 1'b0);
		// Half steps make pixels 0 and 1 of row 1 share the keyed texel
		load_copy_setup();
		tex_dx_i <= 18'sd32;
		chroma_key_en_i <= 1'b1;
		chroma_key_i <= texel_at(TEX_BASE + adr_t'(TEX_HRES));
		run_test("chroma_key", 1'b0);
		load_copy_setup();
		rand_mode <= 1'b1;
		run_test("back_pressure", 1'b0);
		rand_mode <= 1'b0;
		load_copy_setup();
		run_test("start_while_busy", 1'b1);
		run_test("second_run", 1'b0);
		bound_fails = int'(tmu_span_top_inst.tmu_span_chk_inst.fail_count);
		$display("Summary: %0d tests, %0d failed, %0d mismatches, %0d checks, %0d assertions",
			tests_run, tests_failed, sb_errors, chk_errors, bound_fails);
		if (tests_failed == 0 && sb_errors == 0 && chk_errors == 0 && bound_fails == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

//--- tmu_span_top.f
rtl/tmu_span_pkg.sv
rtl/tmu_span_if.sv
rtl/span_ctrl_fsm.sv
rtl/pixel_walker.sv
rtl/tex_addr_gen.sv
rtl/texel_fetch.sv
rtl/color_decay.sv
rtl/tmu_span_top.sv
verification/tmu_span_chk.sv
verification/tmu_span_tb.sv

//--- Makefile
# Verilator build and run of the texture span unit testbench

SRCS := $(shell cat tmu_span_top.f)

.PHONY: all run clean

all: obj_dir/Vtmu_span_tb

obj_dir/Vtmu_span_tb: tmu_span_top.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tmu_span_tb \
		-f tmu_span_top.f -o Vtmu_span_tb

# The log decides the result, since the binary can exit cleanly on a failed run
run: obj_dir/Vtmu_span_tb
	./obj_dir/Vtmu_span_tb +verilator+error+limit+1000 | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
